// ==== hw/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path and address width
`define RV_XLEN       32

// architectural register file
`define RV_NUM_REGS   32
`define RV_REG_ADDR_W 5

// first fetch address after reset
`define RV_RESET_PC   32'h0000_0000

// sequential fetch increment, one 32-bit instruction
`define RV_PC_STEP    32'd4

`endif

// ==== hw/rv_pkg.sv ====
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]       word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes handled by the core
    // anything else retires as a no-op
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011
    } opcode_t;

    // alu function codes
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SLL   = 4'd1,
        ALU_XOR   = 4'd4,
        ALU_SRL   = 4'd5,
        ALU_OR    = 4'd6,
        ALU_AND   = 4'd7,
        ALU_COPY1 = 4'd8,
        ALU_SUB   = 4'd10,
        ALU_SRA   = 4'd11,
        ALU_SLT   = 4'd12,
        ALU_SLTU  = 4'd14
    } alu_op_t;

    // fetch to execute
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_t;

    // decoded fields of the instruction in execute
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic [2:0] funct3;
        word_t     imm;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      is_branch;
        logic      writes_rd;
    } decoded_t;

    // taken branch from execute back to fetch
    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    // writeback record driving the retire port
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
        reg_addr_t rd;
        logic      wr_en;
        word_t     data;
    } retire_t;

endpackage

// ==== hw/rv_alu.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_alu import rv_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_SLL:   result = a << shamt;
            ALU_SRL:   result = a >> shamt;
            // true arithmetic shift, sign bit fills from the left
            ALU_SRA:   result = word_t'($signed(a) >>> shamt);
            ALU_XOR:   result = a ^ b;
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_SLT:   result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:  result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            ALU_COPY1: result = a;
            default:   result = '0;
        endcase
    end

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_decode import rv_pkg::*; (
    input  word_t    inst,
    output decoded_t dec
);

    logic [2:0] funct3;
    logic       alt;
    word_t      imm_i;
    word_t      imm_b;

    // funct3 to alu code, alt selects SUB / SRA
    function automatic alu_op_t alu_map(input logic [2:0] f3, input logic sel_alt);
        alu_op_t op;
        case (f3)
            3'd0:    op = sel_alt ? ALU_SUB : ALU_ADD;
            3'd1:    op = ALU_SLL;
            3'd2:    op = ALU_SLT;
            3'd3:    op = ALU_SLTU;
            3'd4:    op = ALU_XOR;
            3'd5:    op = sel_alt ? ALU_SRA : ALU_SRL;
            3'd6:    op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign funct3 = inst[14:12];
    // funct7 bit 5
    assign alt    = inst[30];

    assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7],
                    inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.rd        = inst[11:7];
        dec.funct3    = funct3;
        dec.imm       = imm_i;
        dec.alu_op    = ALU_ADD;
        dec.use_imm   = 1'b0;
        dec.is_branch = 1'b0;
        dec.writes_rd = 1'b0;

        case (inst[6:0])
            OP_IMM: begin
                // immediate ADDI has no SUB form, bit 30 is part of the immediate
                dec.alu_op    = alu_map(funct3, alt && (funct3 == 3'd5));
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OP_REG: begin
                dec.alu_op    = alu_map(funct3, alt);
                dec.writes_rd = 1'b1;
            end
            OP_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
            end
            default: begin
                // unsupported opcode, retires without effect
                dec.alu_op = ALU_COPY1;
            end
        endcase
    end

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_regfile import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  retire_t   retire
);

    word_t regs [`RV_NUM_REGS];

    // x0 stays zero, wr_en is never set for rd 0
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.wr_en) begin
            regs[retire.rd] <= retire.data;
        end
    end

endmodule

// ==== hw/rv_fetch.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_fetch import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  word_t     imem_data,
    input  redirect_t redirect,
    output word_t     imem_addr,
    output fetch_t    fetch
);

    word_t pc;
    // request issued last cycle, its data is on imem_data now
    word_t req_pc;
    logic  req_valid;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= `RV_RESET_PC;
            req_valid <= 1'b0;
        end else if (redirect.valid) begin
            // in-flight request belongs to the wrong path
            pc        <= redirect.target;
            req_valid <= 1'b0;
        end else begin
            pc        <= pc + `RV_PC_STEP;
            req_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        req_pc <= pc;
    end

    // pair returned instruction with its address
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch.valid <= 1'b0;
        end else begin
            // record arriving during a redirect is the first younger instruction
            fetch.valid <= req_valid && !redirect.valid;
        end
        fetch.pc   <= req_pc;
        fetch.inst <= imem_data;
    end

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/100ps

module rv_execute import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  fetch_t    fetch,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output redirect_t redirect,
    output retire_t   retire
);

    decoded_t dec;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_b;
    word_t    alu_result;
    logic     taken;
    logic     wr_en_next;

    rv_decode u_decode (
        .inst (fetch.inst),
        .dec  (dec)
    );

    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    // bypass from writeback, regfile write lands at the end of this cycle
    assign op_a = (retire.wr_en && (retire.rd == dec.rs1)) ? retire.data : rs1_data;
    assign op_b = (retire.wr_en && (retire.rd == dec.rs2)) ? retire.data : rs2_data;

    assign alu_b = dec.use_imm ? dec.imm : op_b;

    rv_alu u_alu (
        .op     (dec.alu_op),
        .a      (op_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // branch condition by funct3
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (op_a == op_b);
            3'b001:  taken = (op_a != op_b);
            3'b100:  taken = ($signed(op_a) < $signed(op_b));
            3'b101:  taken = ($signed(op_a) >= $signed(op_b));
            3'b110:  taken = (op_a < op_b);
            3'b111:  taken = (op_a >= op_b);
            default: taken = 1'b0;
        endcase
    end

    assign redirect.valid  = fetch.valid && dec.is_branch && taken;
    assign redirect.target = fetch.pc + dec.imm;

    // only place where a register write is qualified
    assign wr_en_next = fetch.valid && dec.writes_rd && (dec.rd != '0);

    // writeback register
    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
            retire.wr_en <= 1'b0;
        end else begin
            retire.valid <= fetch.valid;
            retire.wr_en <= wr_en_next;
        end
        retire.pc   <= fetch.pc;
        retire.inst <= fetch.inst;
        retire.rd   <= dec.rd;
        retire.data <= wr_en_next ? alu_result : '0;
    end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    output word_t   imem_addr,
    input  word_t   imem_data,
    output retire_t retire
);

    fetch_t    fetch;
    redirect_t redirect;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // fetch stage, pc and instruction memory request
    rv_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .imem_data (imem_data),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .fetch     (fetch)
    );

    // decode, execute and writeback register
    rv_execute u_execute (
        .clk      (clk),
        .reset    (reset),
        .fetch    (fetch),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .redirect (redirect),
        .retire   (retire)
    );

    // written from the retire record
    rv_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .retire   (retire)
    );

endmodule

// ==== verif/rv_core_assertions.sv ====
`timescale 1ns/100ps

module rv_core_assertions import rv_pkg::*; (
    input logic      clk,
    input logic      reset,
    input word_t     imem_addr,
    input retire_t   retire,
    input redirect_t redirect
);

    // writeback register comes out of reset empty
    a_no_retire_in_reset: assert property (
        @(posedge clk) reset |=> !retire.valid
    ) else $error("retire.valid high after a reset cycle");

    a_addr_aligned: assert property (
        @(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00
    ) else $error("imem_addr is not word aligned");

    // x0 is never a write target
    a_wr_en_rd: assert property (
        @(posedge clk) disable iff (reset)
            (retire.valid && retire.wr_en) |-> (retire.rd != '0)
    ) else $error("retire.wr_en set with rd of zero");

    // branch itself retires next cycle, then two killed slots
    a_redirect_bubble: assert property (
        @(posedge clk) disable iff (reset)
            redirect.valid |-> ##2 !retire.valid ##1 !retire.valid
    ) else $error("instruction retired in a slot killed by a taken branch");

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .retire    (retire),
    .redirect  (redirect)
);

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20;
    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;

    typedef struct packed {
        word_t     pc;
        logic      wr_en;
        reg_addr_t rd;
        word_t     data;
    } expect_t;

    logic    clk;
    logic    reset;
    word_t   imem_addr;
    word_t   imem_data;
    retire_t retire;

    word_t   prog [$];
    expect_t expected [$];

    int value_errors;
    int timeout_errors;
    int checked;

    rv_core uut (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // instruction memory, data one cycle after the address
    always @(posedge clk) begin
        if ((imem_addr >> 2) < prog.size()) begin
            imem_data <= prog[imem_addr >> 2];
        end else begin
            imem_data <= NOP;
        end
    end

    function automatic word_t i_type(input logic [2:0] f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    // instruction that retires, with its expected writeback
    task automatic emit(input word_t inst, input logic wr_en, input reg_addr_t rd,
                        input word_t data);
        expect_t e;
        e.pc    = `RV_PC_STEP * prog.size();
        e.wr_en = wr_en;
        e.rd    = rd;
        e.data  = data;
        expected.push_back(e);
        prog.push_back(inst);
    endtask

    // taken branch to +12, the two wrong-path slots would write x31
    task automatic emit_taken(input word_t inst);
        emit(inst, 1'b0, 5'd0, 32'h0);
        prog.push_back(i_type(3'd0, 5'd31, 5'd0, 12'h001));
        prog.push_back(i_type(3'd0, 5'd31, 5'd0, 12'h002));
    endtask

    task automatic check_word(input string name, input word_t pc, input word_t got,
                              input word_t exp);
        assert (got === exp) else begin
            $display("ERROR %s at pc 0x%h: expected 0x%h, got 0x%h", name, pc, exp, got);
            value_errors++;
        end
    endtask

    task automatic build_program();
        // I-type on x1 = -5 and x2 = 3
        emit(i_type(3'd0, 5'd1, 5'd0, 12'hffb), 1'b1, 5'd1, 32'hffff_fffb);
        emit(i_type(3'd0, 5'd2, 5'd0, 12'h003), 1'b1, 5'd2, 32'h0000_0003);
        emit(i_type(3'd2, 5'd3, 5'd1, 12'h001), 1'b1, 5'd3, 32'h0000_0001);
        emit(i_type(3'd3, 5'd4, 5'd1, 12'h001), 1'b1, 5'd4, 32'h0000_0000);
        emit(i_type(3'd4, 5'd5, 5'd2, 12'h0f0), 1'b1, 5'd5, 32'h0000_00f3);
        emit(i_type(3'd6, 5'd6, 5'd2, 12'h100), 1'b1, 5'd6, 32'h0000_0103);
        emit(i_type(3'd7, 5'd7, 5'd1, 12'h0ff), 1'b1, 5'd7, 32'h0000_00fb);
        emit(i_type(3'd1, 5'd8, 5'd1, 12'h004), 1'b1, 5'd8, 32'hffff_ffb0);
        emit(i_type(3'd5, 5'd9, 5'd1, 12'h01c), 1'b1, 5'd9, 32'h0000_000f);
        // srai, funct7 0100000 sits in imm[11:5]
        emit(i_type(3'd5, 5'd10, 5'd1, 12'h401), 1'b1, 5'd10, 32'hffff_fffd);
        // R-type
        emit(r_type(7'h00, 3'd0, 5'd11, 5'd1, 5'd2), 1'b1, 5'd11, 32'hffff_fffe);
        emit(r_type(7'h20, 3'd0, 5'd12, 5'd2, 5'd1), 1'b1, 5'd12, 32'h0000_0008);
        emit(r_type(7'h00, 3'd1, 5'd13, 5'd2, 5'd2), 1'b1, 5'd13, 32'h0000_0018);
        emit(r_type(7'h00, 3'd2, 5'd14, 5'd1, 5'd2), 1'b1, 5'd14, 32'h0000_0001);
        emit(r_type(7'h00, 3'd3, 5'd15, 5'd1, 5'd2), 1'b1, 5'd15, 32'h0000_0000);
        emit(r_type(7'h00, 3'd4, 5'd16, 5'd1, 5'd2), 1'b1, 5'd16, 32'hffff_fff8);
        emit(r_type(7'h00, 3'd5, 5'd17, 5'd1, 5'd2), 1'b1, 5'd17, 32'h1fff_ffff);
        emit(r_type(7'h20, 3'd5, 5'd18, 5'd8, 5'd2), 1'b1, 5'd18, 32'hffff_fff6);
        emit(r_type(7'h00, 3'd6, 5'd19, 5'd5, 5'd6), 1'b1, 5'd19, 32'h0000_01f3);
        emit(r_type(7'h00, 3'd7, 5'd20, 5'd5, 5'd7), 1'b1, 5'd20, 32'h0000_00f3);
        // back-to-back dependencies on rs1, rs2, then both
        emit(i_type(3'd0, 5'd21, 5'd2, 12'h007), 1'b1, 5'd21, 32'h0000_000a);
        emit(r_type(7'h00, 3'd0, 5'd22, 5'd21, 5'd2), 1'b1, 5'd22, 32'h0000_000d);
        emit(r_type(7'h20, 3'd0, 5'd23, 5'd2, 5'd22), 1'b1, 5'd23, 32'hffff_fff6);
        emit(r_type(7'h00, 3'd0, 5'd24, 5'd23, 5'd23), 1'b1, 5'd24, 32'hffff_ffec);
        // write to x0 is dropped, next read of x0 is zero
        emit(i_type(3'd0, 5'd0, 5'd2, 12'h005), 1'b0, 5'd0, 32'h0);
        emit(r_type(7'h00, 3'd0, 5'd25, 5'd0, 5'd2), 1'b1, 5'd25, 32'h0000_0003);
        // beq, bne, blt, bge, bltu, bgeu: taken then not taken
        emit_taken(b_type(3'd0, 5'd2, 5'd2, 13'd12));
        emit(b_type(3'd0, 5'd1, 5'd2, 13'd12), 1'b0, 5'd0, 32'h0);
        emit_taken(b_type(3'd1, 5'd1, 5'd2, 13'd12));
        emit(b_type(3'd1, 5'd2, 5'd2, 13'd12), 1'b0, 5'd0, 32'h0);
        emit_taken(b_type(3'd4, 5'd1, 5'd2, 13'd12));
        emit(b_type(3'd4, 5'd2, 5'd1, 13'd12), 1'b0, 5'd0, 32'h0);
        emit_taken(b_type(3'd5, 5'd2, 5'd1, 13'd12));
        emit(b_type(3'd5, 5'd1, 5'd2, 13'd12), 1'b0, 5'd0, 32'h0);
        emit_taken(b_type(3'd6, 5'd2, 5'd1, 13'd12));
        emit(b_type(3'd6, 5'd1, 5'd2, 13'd12), 1'b0, 5'd0, 32'h0);
        emit_taken(b_type(3'd7, 5'd1, 5'd2, 13'd12));
        emit(b_type(3'd7, 5'd2, 5'd1, 13'd12), 1'b0, 5'd0, 32'h0);
        // branch on a forwarded operand
        emit(i_type(3'd0, 5'd26, 5'd0, 12'hffe), 1'b1, 5'd26, 32'hffff_fffe);
        emit_taken(b_type(3'd0, 5'd26, 5'd11, 13'd12));
        emit(r_type(7'h00, 3'd0, 5'd27, 5'd26, 5'd14), 1'b1, 5'd27, 32'hffff_ffff);
        // x31 still zero, wrong-path writes never landed
        emit(i_type(3'd0, 5'd28, 5'd31, 12'h000), 1'b1, 5'd28, 32'h0);
    endtask

    initial begin
        int      waited;
        expect_t e;

        reset          = 1'b1;
        imem_data      = NOP;
        value_errors   = 0;
        timeout_errors = 0;
        checked        = 0;
        build_program();

        // four reset edges, outputs checked between them
        @(posedge clk);
        repeat (3) begin
            @(negedge clk);
            check_word("retire.valid", `RV_RESET_PC, {31'b0, retire.valid}, 32'h0);
            check_word("imem_addr", `RV_RESET_PC, imem_addr, `RV_RESET_PC);
            @(posedge clk);
        end
        reset <= 1'b0;

        for (int i = 0; i < expected.size(); i++) begin
            e      = expected[i];
            waited = 0;
            @(negedge clk);
            while (retire.valid !== 1'b1 && waited < TIMEOUT_CYCLES) begin
                @(negedge clk);
                waited++;
            end
            if (retire.valid !== 1'b1) begin
                $display("no instruction retired within %0d cycles while waiting for pc 0x%h",
                         TIMEOUT_CYCLES, e.pc);
                timeout_errors++;
                break;
            end
            check_word("retire.pc", e.pc, retire.pc, e.pc);
            check_word("retire.inst", e.pc, retire.inst, prog[e.pc >> 2]);
            check_word("retire.wr_en", e.pc, {31'b0, retire.wr_en}, {31'b0, e.wr_en});
            if (e.wr_en) begin
                check_word("retire.rd", e.pc, {27'b0, retire.rd}, {27'b0, e.rd});
            end
            check_word("retire.data", e.pc, retire.data, e.data);
            checked++;
        end

        $display("%0d of %0d retires checked, %0d value errors, %0d timeouts",
                 checked, expected.size(), value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/rv_pkg.sv
hw/rv_alu.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_fetch.sv
hw/rv_execute.sv
hw/rv_core.sv
verif/rv_core_assertions.sv
verif/rv_core_tb.sv
